// ==== cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath and register file geometry
`define CPU_XLEN        32
`define CPU_REG_COUNT   32
`define CPU_REG_ADDR_W  5

// First fetch address after reset
`define CPU_RESET_PC    32'h0000_0000

// addi x0, x0, 0
`define CPU_NOP         32'h0000_0013

`endif

// ==== cpu_pkg.sv ====
`include "cpu_config.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0]       word_t;
    typedef logic [`CPU_REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } branch_e;

    typedef enum logic [1:0] {
        WB_ALU, WB_MEM, WB_PC4
    } wb_sel_e;

    typedef struct packed {
        logic    rs1_en;
        logic    rs2_en;
        logic    rd_en;
        wb_sel_e wb_sel;
        logic    a_pc;
        logic    b_imm;
        alu_op_e alu_op;
        branch_e br_type;
        logic    jal;
        logic    jalr;
        logic    load;
        logic    store;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        ctrl_t     ctrl;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     rs1_val;
        word_t     rs2_val;
        word_t     imm;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        word_t     pc4;
        ctrl_t     ctrl;
        reg_addr_t rd;
        word_t     alu_res;
        word_t     store_data;
    } ex_mw_t;

    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        word_t     data;
    } rf_wr_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

endpackage

// ==== decoder.sv ====
module decoder import cpu_pkg::*; (
    input  word_t instr,
    output ctrl_t ctrl,
    output word_t imm
);

    opcode_e    opc;
    logic [2:0] f3;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    function automatic alu_op_e alu_from_funct(input logic [2:0] funct3, input logic alt);
        alu_op_e op;
        case (funct3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opc = opcode_e'(instr[6:0]);
    assign f3  = instr[14:12];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (opc)
            OP_LUI: begin
                ctrl.rd_en  = 1'b1;
                ctrl.b_imm  = 1'b1;
                ctrl.alu_op = ALU_PASS_B;
                imm         = imm_u;
            end
            OP_AUIPC: begin
                ctrl.rd_en = 1'b1;
                ctrl.a_pc  = 1'b1;
                ctrl.b_imm = 1'b1;
                imm        = imm_u;
            end
            OP_JAL: begin
                ctrl.rd_en  = 1'b1;
                ctrl.wb_sel = WB_PC4;
                ctrl.a_pc   = 1'b1;
                ctrl.b_imm  = 1'b1;
                ctrl.jal    = 1'b1;
                imm         = imm_j;
            end
            OP_JALR: begin
                ctrl.rs1_en = 1'b1;
                ctrl.rd_en  = 1'b1;
                ctrl.wb_sel = WB_PC4;
                ctrl.b_imm  = 1'b1;
                ctrl.jalr   = 1'b1;
                imm         = imm_i;
            end
            OP_BRANCH: begin
                ctrl.rs1_en = 1'b1;
                ctrl.rs2_en = 1'b1;
                ctrl.a_pc   = 1'b1;
                ctrl.b_imm  = 1'b1;
                imm         = imm_b;
                case (f3)
                    3'b000:  ctrl.br_type = BR_EQ;
                    3'b001:  ctrl.br_type = BR_NE;
                    3'b100:  ctrl.br_type = BR_LT;
                    3'b101:  ctrl.br_type = BR_GE;
                    3'b110:  ctrl.br_type = BR_LTU;
                    3'b111:  ctrl.br_type = BR_GEU;
                    default: ctrl.br_type = BR_NONE;
                endcase
            end
            OP_LOAD: begin
                // Word access only
                if (f3 == 3'b010) begin
                    ctrl.rs1_en = 1'b1;
                    ctrl.rd_en  = 1'b1;
                    ctrl.wb_sel = WB_MEM;
                    ctrl.b_imm  = 1'b1;
                    ctrl.load   = 1'b1;
                    imm         = imm_i;
                end
            end
            OP_STORE: begin
                if (f3 == 3'b010) begin
                    ctrl.rs1_en = 1'b1;
                    ctrl.rs2_en = 1'b1;
                    ctrl.b_imm  = 1'b1;
                    ctrl.store  = 1'b1;
                    imm         = imm_s;
                end
            end
            OP_IMM: begin
                ctrl.rs1_en = 1'b1;
                ctrl.rd_en  = 1'b1;
                ctrl.b_imm  = 1'b1;
                ctrl.alu_op = alu_from_funct(f3, (f3 == 3'b101) && instr[30]);
                imm         = imm_i;
            end
            OP_REG: begin
                ctrl.rs1_en = 1'b1;
                ctrl.rs2_en = 1'b1;
                ctrl.rd_en  = 1'b1;
                ctrl.alu_op = alu_from_funct(f3, instr[30]);
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== reg_file.sv ====
`include "cpu_config.svh"

module reg_file import cpu_pkg::*; (
    input  logic      clk,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output word_t     rd1,
    output word_t     rd2,
    input  rf_wr_t    wr
);

    word_t regs [0:`CPU_REG_COUNT-1];

    // Same-cycle write is visible to the reader
    assign rd1 = (rs1 == '0) ? '0 : (wr.en && wr.addr == rs1) ? wr.data : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : (wr.en && wr.addr == rs2) ? wr.data : regs[rs2];

    always_ff @(posedge clk) begin
        if (wr.en && wr.addr != '0) begin
            regs[wr.addr] <= wr.data;
        end
    end

endmodule

// ==== alu.sv ====
module alu import cpu_pkg::*; (
    input  alu_op_e op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result,
    input  branch_e br_type,
    input  word_t   br_a,
    input  word_t   br_b,
    output logic    taken
);

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_XOR:    result = a ^ b;
            ALU_SLT:    result = word_t'($signed(a) < $signed(b));
            ALU_SLTU:   result = word_t'(a < b);
            ALU_SLL:    result = a << b[4:0];
            ALU_SRL:    result = a >> b[4:0];
            ALU_SRA:    result = word_t'($signed(a) >>> b[4:0]);
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

    always_comb begin
        case (br_type)
            BR_EQ:   taken = (br_a == br_b);
            BR_NE:   taken = (br_a != br_b);
            BR_LT:   taken = ($signed(br_a) < $signed(br_b));
            BR_GE:   taken = ($signed(br_a) >= $signed(br_b));
            BR_LTU:  taken = (br_a < br_b);
            BR_GEU:  taken = (br_a >= br_b);
            default: taken = 1'b0;
        endcase
    end

endmodule

// ==== fetch_stage.sv ====
`include "cpu_config.svh"

module fetch_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      freeze,
    input  redirect_t redirect,
    input  logic      im_rready,
    input  word_t     im_dout,
    output logic      im_rvalid,
    output word_t     im_addr,
    output if_id_t    if_id
);

    word_t pc;
    word_t pc_plus4;
    logic  fetch_en;
    logic  fetch_done;
    logic  redir_pend;
    word_t redir_pc;
    logic  jump;
    word_t jump_pc;

    assign pc_plus4   = pc + 32'd4;
    assign im_rvalid  = fetch_en;
    assign im_addr    = pc;
    assign fetch_done = im_rvalid && im_rready;

    // A redirect seen while a fetch waits is kept until that fetch ends
    assign jump    = redir_pend || redirect.valid;
    assign jump_pc = redir_pend ? redir_pc : redirect.target;

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_en   <= 1'b0;
            pc         <= `CPU_RESET_PC;
            redir_pend <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
            if (!freeze) begin
                if (fetch_done) begin
                    pc         <= jump ? jump_pc : pc_plus4;
                    redir_pend <= 1'b0;
                end else if (redirect.valid) begin
                    redir_pend <= 1'b1;
                    redir_pc   <= redirect.target;
                end
            end
        end
    end

    // Fetched word from a wrong path becomes a bubble
    always_ff @(posedge clk) begin
        if (rst) begin
            if_id.valid <= 1'b0;
        end else if (!freeze) begin
            if_id.valid <= fetch_done && !jump;
            if_id.pc    <= pc;
            if_id.instr <= (fetch_done && !jump) ? im_dout : `CPU_NOP;
        end
    end

endmodule

// ==== decode_stage.sv ====
module decode_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      freeze,
    input  redirect_t redirect,
    input  if_id_t    if_id,
    input  rf_wr_t    wr,
    output id_ex_t    id_ex
);

    ctrl_t dec_ctrl;
    word_t dec_imm;
    word_t rs1_val;
    word_t rs2_val;

    decoder u_decoder (
        .instr (if_id.instr),
        .ctrl  (dec_ctrl),
        .imm   (dec_imm)
    );

    reg_file u_reg_file (
        .clk (clk),
        .rs1 (if_id.instr[19:15]),
        .rs2 (if_id.instr[24:20]),
        .rd1 (rs1_val),
        .rd2 (rs2_val),
        .wr  (wr)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex.valid <= 1'b0;
        end else if (!freeze) begin
            id_ex.valid   <= if_id.valid && !redirect.valid;
            id_ex.pc      <= if_id.pc;
            id_ex.ctrl    <= dec_ctrl;
            id_ex.rs1     <= if_id.instr[19:15];
            id_ex.rs2     <= if_id.instr[24:20];
            id_ex.rd      <= if_id.instr[11:7];
            id_ex.rs1_val <= rs1_val;
            id_ex.rs2_val <= rs2_val;
            id_ex.imm     <= dec_imm;
        end
    end

endmodule

// ==== exec_mem_stage.sv ====
module exec_mem_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  id_ex_t    id_ex,
    output redirect_t redirect,
    output logic      freeze,
    output rf_wr_t    wr,
    output logic      dm_rvalid,
    output logic      dm_wvalid,
    input  logic      dm_rready,
    input  logic      dm_wready,
    output word_t     dm_addr,
    output word_t     dm_din,
    input  word_t     dm_dout
);

    ex_mw_t ex_mw;
    ctrl_t  ex_ctrl;
    word_t  rs1_val;
    word_t  rs2_val;
    word_t  op_a;
    word_t  op_b;
    word_t  alu_res;
    logic   taken;
    logic   mw_wb;
    word_t  wb_data;

    assign ex_ctrl = id_ex.ctrl;

    // Forward from MW, load data comes straight off dm_dout
    assign mw_wb   = ex_mw.valid && ex_mw.ctrl.rd_en && (ex_mw.rd != '0);
    assign rs1_val = (ex_ctrl.rs1_en && mw_wb && ex_mw.rd == id_ex.rs1) ? wb_data : id_ex.rs1_val;
    assign rs2_val = (ex_ctrl.rs2_en && mw_wb && ex_mw.rd == id_ex.rs2) ? wb_data : id_ex.rs2_val;

    assign op_a = ex_ctrl.a_pc ? id_ex.pc : rs1_val;
    assign op_b = ex_ctrl.b_imm ? id_ex.imm : rs2_val;

    alu u_alu (
        .op      (ex_ctrl.alu_op),
        .a       (op_a),
        .b       (op_b),
        .result  (alu_res),
        .br_type (ex_ctrl.br_type),
        .br_a    (rs1_val),
        .br_b    (rs2_val),
        .taken   (taken)
    );

    // ALU computes every target, jalr drops bit 0
    assign redirect.valid  = id_ex.valid && (ex_ctrl.jal || ex_ctrl.jalr || taken);
    assign redirect.target = {alu_res[31:1], alu_res[0] & ~ex_ctrl.jalr};

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mw.valid <= 1'b0;
        end else if (!freeze) begin
            ex_mw.valid      <= id_ex.valid;
            ex_mw.pc4        <= id_ex.pc + 32'd4;
            ex_mw.ctrl       <= ex_ctrl;
            ex_mw.rd         <= id_ex.rd;
            ex_mw.alu_res    <= alu_res;
            ex_mw.store_data <= rs2_val;
        end
    end

    assign dm_rvalid = ex_mw.valid && ex_mw.ctrl.load;
    assign dm_wvalid = ex_mw.valid && ex_mw.ctrl.store;
    assign dm_addr   = ex_mw.alu_res;
    assign dm_din    = ex_mw.store_data;

    // Whole pipeline waits on the data bus
    assign freeze = (dm_rvalid && !dm_rready) || (dm_wvalid && !dm_wready);

    always_comb begin
        case (ex_mw.ctrl.wb_sel)
            WB_MEM:  wb_data = dm_dout;
            WB_PC4:  wb_data = ex_mw.pc4;
            default: wb_data = ex_mw.alu_res;
        endcase
    end

    assign wr.en   = mw_wb && !freeze;
    assign wr.addr = ex_mw.rd;
    assign wr.data = wb_data;

endmodule

// ==== cpu.sv ====
module cpu import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    // Instruction bus
    output logic  im_rvalid,
    input  logic  im_rready,
    output word_t im_addr,
    input  word_t im_dout,

    // Data bus
    output word_t dm_addr,
    output logic  dm_rvalid,
    input  logic  dm_rready,
    output logic  dm_wvalid,
    input  logic  dm_wready,
    input  word_t dm_dout,
    output word_t dm_din
);

    if_id_t    if_id;
    id_ex_t    id_ex;
    rf_wr_t    wr;
    redirect_t redirect;
    logic      freeze;

    fetch_stage u_fetch (
        .clk       (clk),
        .rst       (rst),
        .freeze    (freeze),
        .redirect  (redirect),
        .im_rready (im_rready),
        .im_dout   (im_dout),
        .im_rvalid (im_rvalid),
        .im_addr   (im_addr),
        .if_id     (if_id)
    );

    decode_stage u_decode (
        .clk      (clk),
        .rst      (rst),
        .freeze   (freeze),
        .redirect (redirect),
        .if_id    (if_id),
        .wr       (wr),
        .id_ex    (id_ex)
    );

    exec_mem_stage u_exec_mem (
        .clk       (clk),
        .rst       (rst),
        .id_ex     (id_ex),
        .redirect  (redirect),
        .freeze    (freeze),
        .wr        (wr),
        .dm_rvalid (dm_rvalid),
        .dm_wvalid (dm_wvalid),
        .dm_rready (dm_rready),
        .dm_wready (dm_wready),
        .dm_addr   (dm_addr),
        .dm_din    (dm_din),
        .dm_dout   (dm_dout)
    );

endmodule

// ==== cpu_properties.sv ====
module cpu_properties import cpu_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  im_rvalid,
    input logic  im_rready,
    input word_t im_addr,
    input logic  dm_rvalid,
    input logic  dm_rready,
    input logic  dm_wvalid,
    input logic  dm_wready,
    input word_t dm_addr,
    input word_t dm_din
);

    a_no_read_write: assert property (@(posedge clk) disable iff (rst)
        !(dm_rvalid && dm_wvalid)) else $error("dm read and write valid together");

    a_read_stable: assert property (@(posedge clk) disable iff (rst)
        dm_rvalid && !dm_rready |=> dm_rvalid && $stable(dm_addr))
        else $error("dm read request changed while waiting");

    a_write_stable: assert property (@(posedge clk) disable iff (rst)
        dm_wvalid && !dm_wready |=> dm_wvalid && $stable(dm_addr) && $stable(dm_din))
        else $error("dm write request changed while waiting");

    a_fetch_stable: assert property (@(posedge clk) disable iff (rst)
        im_rvalid && !im_rready |=> im_rvalid && $stable(im_addr))
        else $error("fetch address changed while waiting");

    // After a reset edge every request is low
    a_reset_quiet: assert property (@(posedge clk)
        rst |=> !im_rvalid && !dm_rvalid && !dm_wvalid)
        else $error("bus valid high during reset");

endmodule

bind cpu cpu_properties u_properties (
    .clk       (clk),
    .rst       (rst),
    .im_rvalid (im_rvalid),
    .im_rready (im_rready),
    .im_addr   (im_addr),
    .dm_rvalid (dm_rvalid),
    .dm_rready (dm_rready),
    .dm_wvalid (dm_wvalid),
    .dm_wready (dm_wready),
    .dm_addr   (dm_addr),
    .dm_din    (dm_din)
);

// ==== tb_cpu.sv ====
`include "cpu_config.svh"

module tb_cpu import cpu_pkg::*; ();

    logic  clk = 1'b0;
    logic  rst;
    logic  im_rvalid;
    logic  im_rready;
    word_t im_addr;
    word_t im_dout;
    word_t dm_addr;
    logic  dm_rvalid;
    logic  dm_rready;
    logic  dm_wvalid;
    logic  dm_wready;
    word_t dm_dout;
    word_t dm_din;

    word_t imem [0:255];
    word_t dmem [0:255];
    word_t exp_addr[$];
    word_t exp_data[$];
    int    prog_len;
    int    n_instr;
    int    n_exp;
    int    n_seen;
    logic  model_done;
    logic  first_fetch_seen;
    int    seed;

    cpu DUT (
        .clk       (clk),
        .rst       (rst),
        .im_rvalid (im_rvalid),
        .im_rready (im_rready),
        .im_addr   (im_addr),
        .im_dout   (im_dout),
        .dm_addr   (dm_addr),
        .dm_rvalid (dm_rvalid),
        .dm_rready (dm_rready),
        .dm_wvalid (dm_wvalid),
        .dm_wready (dm_wready),
        .dm_dout   (dm_dout),
        .dm_din    (dm_din)
    );

    assign im_dout = imem[im_addr[9:2]];
    assign dm_dout = dmem[dm_addr[9:2]];

    initial begin
        forever #5 clk = ~clk;
    end

    // Instruction encoders
    function automatic word_t enc_r(word_t f7, word_t rs2, word_t rs1, word_t f3, word_t rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_REG};
    endfunction

    function automatic word_t enc_i(word_t imm, word_t rs1, word_t f3, word_t rd,
                                    logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic word_t enc_s(word_t imm, word_t rs2, word_t rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t enc_b(word_t imm, word_t rs1, word_t rs2, word_t f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic word_t enc_u(word_t imm, word_t rd, logic [6:0] op);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic word_t enc_j(word_t imm, word_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
    endfunction

    // Initial data memory contents
    function automatic word_t fill_word(word_t idx);
        return (idx * 32'h9e37_79b9) ^ 32'h5a5a_0000 ^ {idx[7:0], 24'h0};
    endfunction

    function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // Architectural model that returns the executed instruction count
    function automatic int run_model();
        word_t r [0:31];
        word_t mem [0:255];
        word_t pc;
        word_t next_pc;
        word_t ins;
        word_t a;
        word_t b;
        word_t addr;
        word_t imm_i;
        word_t imm_s;
        word_t imm_b;
        word_t imm_j;
        logic  take;
        int    steps;
        for (int i = 0; i < 32; i++) r[i] = '0;
        for (int i = 0; i < 256; i++) mem[i] = fill_word(i);
        pc    = `CPU_RESET_PC;
        steps = 0;
        while (steps < 2000) begin
            ins = imem[pc[9:2]];
            if (ins == enc_j(0, 0)) break;
            steps++;
            a       = r[ins[19:15]];
            b       = r[ins[24:20]];
            imm_i   = {{20{ins[31]}}, ins[31:20]};
            imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            next_pc = pc + 4;
            case (ins[6:0])
                OP_LUI:   r[ins[11:7]] = {ins[31:12], 12'b0};
                OP_AUIPC: r[ins[11:7]] = pc + {ins[31:12], 12'b0};
                OP_IMM:   r[ins[11:7]] = alu_ref(ins[14:12], ins[14:12] == 3'd5 && ins[30],
                                                 a, imm_i);
                OP_REG:   r[ins[11:7]] = alu_ref(ins[14:12], ins[30], a, b);
                OP_LOAD: begin
                    addr         = a + imm_i;
                    r[ins[11:7]] = mem[addr[9:2]];
                end
                OP_STORE: begin
                    addr           = a + imm_s;
                    mem[addr[9:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                OP_BRANCH: begin
                    case (ins[14:12])
                        3'd0:    take = (a == b);
                        3'd1:    take = (a != b);
                        3'd4:    take = ($signed(a) < $signed(b));
                        3'd5:    take = ($signed(a) >= $signed(b));
                        3'd6:    take = (a < b);
                        default: take = (a >= b);
                    endcase
                    if (take) next_pc = pc + imm_b;
                end
                OP_JAL: begin
                    r[ins[11:7]] = pc + 4;
                    next_pc      = pc + imm_j;
                end
                OP_JALR: begin
                    next_pc      = (a + imm_i) & ~32'd1;
                    r[ins[11:7]] = pc + 4;
                end
                default: begin
                end
            endcase
            r[0] = '0;
            pc   = next_pc;
        end
        return steps;
    endfunction

    task automatic emit(word_t ins);
        imem[prog_len[7:0]] = ins;
        prog_len++;
    endtask

    task automatic emit_store(word_t rs2, word_t off);
        emit(enc_s(off, rs2, 1));
    endtask

    // A taken branch skips the store after it
    task automatic emit_branch(word_t f3, word_t rs1, word_t rs2, word_t off);
        emit(enc_b(8, rs1, rs2, f3));
        emit_store(4, off);
    endtask

    task automatic build_program();
        prog_len = 0;
        for (int i = 0; i < 256; i++) imem[i] = `CPU_NOP;
        emit(enc_i(32'h100, 0, 0, 1, OP_IMM));
        emit(enc_i(5, 0, 0, 2, OP_IMM));
        emit(enc_i(-3, 0, 0, 3, OP_IMM));
        emit(enc_r(0, 3, 2, 0, 4));
        emit_store(4, 0);
        emit(enc_r(32'h20, 2, 4, 0, 5));
        emit_store(5, 4);
        emit(enc_r(0, 3, 2, 7, 6));
        emit(enc_r(0, 2, 6, 6, 7));
        emit(enc_r(0, 3, 7, 4, 8));
        emit_store(8, 8);
        emit(enc_r(0, 2, 3, 2, 9));
        emit(enc_r(0, 2, 3, 3, 10));
        emit_store(9, 12);
        emit_store(10, 16);
        emit(enc_r(0, 2, 3, 1, 11));
        emit(enc_r(0, 2, 3, 5, 12));
        emit(enc_r(32'h20, 2, 3, 5, 13));
        emit_store(11, 20);
        emit_store(12, 24);
        emit_store(13, 28);
        emit(enc_i(32'h55, 3, 4, 14, OP_IMM));
        emit(enc_i(32'h401, 3, 5, 15, OP_IMM));
        emit_store(14, 32);
        emit_store(15, 36);
        emit(enc_u(32'h12345, 16, OP_LUI));
        emit(enc_u(32'h1, 17, OP_AUIPC));
        emit_store(16, 40);
        emit_store(17, 44);
        // Load straight into a dependent store and then into the ALU
        emit(enc_i(32'h40, 0, 0, 20, OP_IMM));
        emit(enc_i(0, 20, 2, 18, OP_LOAD));
        emit_store(18, 48);
        emit(enc_i(4, 1, 2, 19, OP_LOAD));
        emit(enc_i(1, 19, 0, 19, OP_IMM));
        emit_store(19, 52);
        emit_branch(0, 2, 2, 60);
        emit_branch(0, 2, 3, 64);
        emit_branch(1, 2, 3, 68);
        emit_branch(1, 2, 2, 72);
        emit_branch(4, 3, 2, 76);
        emit_branch(4, 2, 3, 80);
        emit_branch(5, 2, 3, 84);
        emit_branch(5, 3, 2, 88);
        emit_branch(6, 2, 3, 92);
        emit_branch(6, 3, 2, 96);
        emit_branch(7, 3, 2, 100);
        emit_branch(7, 2, 3, 104);
        emit(enc_j(8, 21));
        emit_store(3, 108);
        emit_store(21, 112);
        emit(enc_u(0, 22, OP_AUIPC));
        emit(enc_i(17, 22, 0, 23, OP_JALR));
        emit_store(3, 120);
        emit_store(3, 124);
        emit_store(23, 116);
        emit(enc_j(0, 0));
    endtask

    task automatic stop_on_error(string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check(string name, word_t got, word_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("error at %0t: %s got %h expected %h",
                                    $time, name, got, exp));
        end
    endtask

    // Ready signals with random gaps
    initial begin
        word_t rnd;
        seed      = 60446;
        im_rready = 1'b0;
        dm_rready = 1'b0;
        dm_wready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            rnd       = $random(seed);
            im_rready = (rnd[1:0] != 2'b00);
            dm_rready = (rnd[3:2] != 2'b00);
            dm_wready = (rnd[5:4] != 2'b00);
        end
    end

    // Compare and data memory update on the falling edge
    always @(negedge clk) begin
        if (rst) begin
            check("im_rvalid", {31'b0, im_rvalid}, '0);
            check("dm_rvalid", {31'b0, dm_rvalid}, '0);
            check("dm_wvalid", {31'b0, dm_wvalid}, '0);
        end else begin
            if (im_rvalid && im_rready) begin
                if (!first_fetch_seen) begin
                    check("im_addr", im_addr, `CPU_RESET_PC);
                    first_fetch_seen = 1'b1;
                end
                // Every fetch is word aligned, jalr included
                check("im_addr[1:0]", {30'b0, im_addr[1:0]}, '0);
            end
            if (dm_wvalid && dm_wready) begin
                if (exp_addr.size() == 0) begin
                    stop_on_error($sformatf("unexpected store to %h at %0t", dm_addr, $time));
                end else begin
                    check("dm_addr", dm_addr, exp_addr.pop_front());
                    check("dm_din", dm_din, exp_data.pop_front());
                    dmem[dm_addr[9:2]] = dm_din;
                    n_seen++;
                end
            end
        end
    end

    initial begin
        wait (model_done);
        repeat (n_instr * 40 + 10) @(posedge clk);
        stop_on_error("timeout: the expected stores did not all appear in time");
    end

    initial begin
        rst              = 1'b1;
        model_done       = 1'b0;
        first_fetch_seen = 1'b0;
        n_seen           = 0;
        for (int i = 0; i < 256; i++) dmem[i] = fill_word(i);
        build_program();
        n_instr    = run_model();
        n_exp      = exp_addr.size();
        model_done = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        wait (n_seen == n_exp);
        // Extra time to catch a late wrong-path or repeated store
        repeat (30) @(posedge clk);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+.
cpu_pkg.sv
decoder.sv
reg_file.sv
alu.sv
fetch_stage.sv
decode_stage.sv
exec_mem_stage.sv
cpu.sv
cpu_properties.sv
tb_cpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
